//--- Makefile
# Verilator flow for the APB subsystem

VERILATOR ?= verilator
TOP ?= tb_apb_subsystem
FILELIST ?= all.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --timing --assert
PASS_TEXT ?= Verification passed

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- all.f
hw/apb_pkg.sv
hw/apb_arbiter.sv
hw/apb_master.sv
hw/apb_reg_bank.sv
hw/apb_wait_mem.sv
hw/apb_protocol_monitor.sv
hw/apb_subsystem.sv
verification/apb_checker.sv
verification/tb_apb_subsystem.sv

//--- hw/apb_arbiter.sv
////////////////////////////////////////
// Round-robin requester arbiter
////////////////////////////////////////

`default_nettype none

module apb_arbiter (
	input  wire                          PCLK,
	input  wire                          arst_n,
	input  wire                          req0,
	input  wire                          write0,
	input  wire  [apb_pkg::APB_AW-1:0]   addr0,
	input  wire  [apb_pkg::APB_DW-1:0]   wdata0,
	input  wire  [apb_pkg::APB_SW-1:0]   strb0,
	output logic                         ack0,
	output logic [apb_pkg::APB_DW-1:0]   rdata0,
	output logic                         err0,
	input  wire                          req1,
	input  wire                          write1,
	input  wire  [apb_pkg::APB_AW-1:0]   addr1,
	input  wire  [apb_pkg::APB_DW-1:0]   wdata1,
	input  wire  [apb_pkg::APB_SW-1:0]   strb1,
	output logic                         ack1,
	output logic [apb_pkg::APB_DW-1:0]   rdata1,
	output logic                         err1,
	output logic                         mreq,
	output logic                         mwrite,
	output logic [apb_pkg::APB_AW-1:0]   maddr,
	output logic [apb_pkg::APB_DW-1:0]   mwdata,
	output logic [apb_pkg::APB_SW-1:0]   mstrb,
	input  wire                          mack,
	input  wire  [apb_pkg::APB_DW-1:0]   mrdata,
	input  wire                          merr
);
	import apb_pkg::*;

	logic busy;
	// Port that holds the master, valid while busy
	logic owner;
	// Port served last, the other one has priority
	logic last;
	logic own0;
	logic own1;
	logic owner_req;

	assign own0 = busy && !owner;
	assign own1 = busy && owner;
	assign owner_req = owner ? req1 : req0;

	////////////////////////////////////////
	// Grant and release
	////////////////////////////////////////

	always_ff @(posedge PCLK or negedge arst_n)
	begin
		if (!arst_n)
		begin
			busy <= 1'b0;
			owner <= 1'b0;
			// Port 0 first after reset
			last <= 1'b1;
		end
		else if (!busy)
		begin
			// New grant only once the last handshake has closed
			if (!mack && (req0 || req1))
			begin
				busy <= 1'b1;
				owner <= !(req0 && (!req1 || last));
			end
		end
		else if (!owner_req && !mack)
		begin
			// Both halves of the four-phase pair are low
			busy <= 1'b0;
			last <= owner;
		end
	end

	////////////////////////////////////////
	// Request and response routing
	////////////////////////////////////////

	assign mreq = busy && owner_req;
	assign mwrite = owner ? write1 : write0;
	assign maddr = owner ? addr1 : addr0;
	assign mwdata = owner ? wdata1 : wdata0;
	assign mstrb = owner ? strb1 : strb0;

	// Only the owner sees the handshake and the reply
	assign ack0 = own0 && mack;
	assign ack1 = own1 && mack;
	assign rdata0 = own0 ? mrdata : '0;
	assign rdata1 = own1 ? mrdata : '0;
	assign err0 = own0 && merr;
	assign err1 = own1 && merr;

	// Never answer both ports
	assert property (@(posedge PCLK) disable iff (!arst_n) !(ack0 && ack1));

	// The master answers only a request that is still up
	assert property (@(posedge PCLK) disable iff (!arst_n)
		$rose(mack) |-> (busy && owner_req));

endmodule

`default_nettype wire

//--- hw/apb_master.sv
////////////////////////////////////////
// APB master and slave decode
////////////////////////////////////////

`default_nettype none

module apb_master (
	input  wire                          PCLK,
	input  wire                          arst_n,
	input  wire                          mreq,
	input  wire                          mwrite,
	input  wire  [apb_pkg::APB_AW-1:0]   maddr,
	input  wire  [apb_pkg::APB_DW-1:0]   mwdata,
	input  wire  [apb_pkg::APB_SW-1:0]   mstrb,
	output logic                         mack,
	output logic [apb_pkg::APB_DW-1:0]   mrdata,
	output logic                         merr,
	output logic                         PSEL_REG,
	output logic                         PSEL_MEM,
	output logic                         PENABLE,
	output logic [apb_pkg::APB_AW-1:0]   PADDR,
	output logic                         PWRITE,
	output logic [apb_pkg::APB_DW-1:0]   PWDATA,
	output logic [apb_pkg::APB_SW-1:0]   PWSTRB,
	input  wire  [apb_pkg::APB_DW-1:0]   prdata_reg,
	input  wire                          pready_reg,
	input  wire                          pslverr_reg,
	input  wire  [apb_pkg::APB_DW-1:0]   prdata_mem,
	input  wire                          pready_mem,
	input  wire                          pslverr_mem,
	output logic                         PREADY,
	output logic                         PSLVERR
);
	import apb_pkg::*;

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_SETUP = 2'd1;
	localparam logic [1:0] ST_ACCESS = 2'd2;
	localparam logic [1:0] ST_DONE = 2'd3;

	logic [1:0] state;
	logic psel;
	logic [APB_DW-1:0] prdata_sel;

	////////////////////////////////////////
	// Slave decode and return mux
	////////////////////////////////////////

	assign PSEL_REG = psel && !PADDR[SEL_BIT];
	assign PSEL_MEM = psel && PADDR[SEL_BIT];
	assign PREADY = (PSEL_REG && pready_reg) || (PSEL_MEM && pready_mem);
	assign PSLVERR = (PSEL_REG && pslverr_reg) || (PSEL_MEM && pslverr_mem);
	assign prdata_sel = PADDR[SEL_BIT] ? prdata_mem : prdata_reg;

	////////////////////////////////////////
	// Transfer FSM
	////////////////////////////////////////

	always_ff @(posedge PCLK or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= ST_IDLE;
			psel <= 1'b0;
			PENABLE <= 1'b0;
			mack <= 1'b0;
		end
		else
		begin
			case (state)
				ST_IDLE:
					// Setup phase starts on the next edge
					if (mreq)
					begin
						state <= ST_SETUP;
						psel <= 1'b1;
					end
				ST_SETUP:
				begin
					state <= ST_ACCESS;
					PENABLE <= 1'b1;
				end
				ST_ACCESS:
					// Stay here while the slave stalls
					if (PREADY)
					begin
						state <= ST_DONE;
						psel <= 1'b0;
						PENABLE <= 1'b0;
						mack <= 1'b1;
					end
				default:
					// Hold the reply until the requester lets go
					if (!mreq)
					begin
						state <= ST_IDLE;
						mack <= 1'b0;
					end
			endcase
		end
	end

	// Fields frozen for the whole transfer, reply captured at completion
	always_ff @(posedge PCLK)
	begin
		if (state == ST_IDLE && mreq)
		begin
			PADDR <= maddr;
			PWRITE <= mwrite;
			PWDATA <= mwdata;
			PWSTRB <= mstrb;
		end
		if (state == ST_ACCESS && PREADY)
		begin
			mrdata <= prdata_sel;
			merr <= PSLVERR;
		end
	end

	// One slave at a time on the shared bus
	assert property (@(posedge PCLK) disable iff (!arst_n) !(PSEL_REG && PSEL_MEM));

endmodule

`default_nettype wire

//--- hw/apb_pkg.sv
////////////////////////////////////////
// APB subsystem shared constants
////////////////////////////////////////

`default_nettype none

package apb_pkg;

	////////////////////////////////////////
	// Bus widths
	////////////////////////////////////////

	// Byte address, 4 KB window
	localparam int APB_AW = 12;
	localparam int APB_DW = 32;
	// One strobe per data byte
	localparam int APB_SW = APB_DW / 8;

	////////////////////////////////////////
	// Address map
	////////////////////////////////////////

	// Low half is the register bank, high half the memory
	localparam int SEL_BIT = 11;

	// Register bank, word index in bits 5..2
	localparam int REG_COUNT = 16;
	localparam logic [APB_DW-1:0] REG_ID_VALUE = 32'hA9B0_0101;

	// Memory, word index in bits 10..2
	localparam int MEM_DEPTH = 64;
	// Extra access cycles per memory transfer
	localparam int MEM_WAIT = 2;

	////////////////////////////////////////
	// Protocol limits
	////////////////////////////////////////

	// Access cycles with PREADY low must stay below this
	localparam int MAX_STALL = 4;

endpackage

`default_nettype wire

//--- hw/apb_protocol_monitor.sv
////////////////////////////////////////
// APB bus protocol monitor
////////////////////////////////////////

`default_nettype none

module apb_protocol_monitor (
	input  wire                          PCLK,
	input  wire                          arst_n,
	input  wire                          PSEL,
	input  wire                          PENABLE,
	input  wire  [apb_pkg::APB_AW-1:0]   PADDR,
	input  wire                          PWRITE,
	input  wire  [apb_pkg::APB_DW-1:0]   PWDATA,
	input  wire  [apb_pkg::APB_SW-1:0]   PWSTRB,
	input  wire                          PREADY,
	input  wire                          PSLVERR
);
	import apb_pkg::*;

	localparam int STALL_W = $clog2(MAX_STALL + 1);

	logic [STALL_W-1:0] stall_cnt;
	logic stalled;

	// Setup, or an access the slave has not finished
	assign stalled = PSEL && (!PENABLE || !PREADY);

	////////////////////////////////////////
	// Stall length
	////////////////////////////////////////

	always_ff @(posedge PCLK or negedge arst_n)
	begin
		if (!arst_n)
			stall_cnt <= '0;
		else if (PSEL && PENABLE && !PREADY)
			stall_cnt <= stall_cnt + 1'b1;
		else
			stall_cnt <= '0;
	end

	////////////////////////////////////////
	// Sequencing rules
	////////////////////////////////////////

	// First selected cycle is always a setup
	assert property (@(posedge PCLK) disable iff (!arst_n) $rose(PSEL) |-> !PENABLE);

	// Setup is followed by access
	assert property (@(posedge PCLK) disable iff (!arst_n)
		PSEL && !PENABLE |=> PSEL && PENABLE);

	// Select holds until the slave completes
	assert property (@(posedge PCLK) disable iff (!arst_n) stalled |=> PSEL);

	// Transfer fields frozen while waiting
	assert property (@(posedge PCLK) disable iff (!arst_n)
		stalled |=> $stable(PADDR) && $stable(PWRITE));
	assert property (@(posedge PCLK) disable iff (!arst_n)
		stalled && PWRITE |=> $stable(PWDATA) && $stable(PWSTRB));

	// Bounded wait
	assert property (@(posedge PCLK) disable iff (!arst_n) stall_cnt < STALL_W'(MAX_STALL));

	// Error only alongside a completing access
	assert property (@(posedge PCLK) disable iff (!arst_n)
		PSLVERR |-> PSEL && PENABLE && PREADY);

endmodule

`default_nettype wire

//--- hw/apb_reg_bank.sv
////////////////////////////////////////
// APB register bank slave
////////////////////////////////////////

`default_nettype none

module apb_reg_bank (
	input  wire                          PCLK,
	input  wire                          arst_n,
	input  wire                          PSEL,
	input  wire                          PENABLE,
	input  wire  [apb_pkg::APB_AW-1:0]   PADDR,
	input  wire                          PWRITE,
	input  wire  [apb_pkg::APB_DW-1:0]   PWDATA,
	input  wire  [apb_pkg::APB_SW-1:0]   PWSTRB,
	output logic [apb_pkg::APB_DW-1:0]   PRDATA,
	output logic                         PREADY,
	output logic                         PSLVERR
);
	import apb_pkg::*;

	localparam int IDX_W = $clog2(REG_COUNT);

	// Storage for registers 1 to 15 only
	// Register 0 returns the ID value
	logic [APB_DW-1:0] regs [1:REG_COUNT-1];
	logic [IDX_W-1:0] idx;
	logic bad_addr;
	logic id_write;
	logic access;

	assign idx = PADDR[IDX_W+1:2];
	// Bits between the index and the slave select must be zero
	assign bad_addr = |PADDR[SEL_BIT-1:IDX_W+2];
	assign id_write = PWRITE && (idx == '0);
	assign access = PSEL && PENABLE;

	////////////////////////////////////////
	// Response
	////////////////////////////////////////

	// Zero wait states
	assign PREADY = 1'b1;
	assign PSLVERR = access && (bad_addr || id_write);

	always_comb
	begin
		if (bad_addr)
			PRDATA = '0;
		else if (idx == '0)
			PRDATA = REG_ID_VALUE;
		else
			PRDATA = regs[idx];
	end

	////////////////////////////////////////
	// Byte-merged writes
	////////////////////////////////////////

	always_ff @(posedge PCLK or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 1; i < REG_COUNT; i++)
				regs[i] <= '0;
		end
		else if (access && PWRITE && !bad_addr && !id_write)
		begin
			// Only the strobed bytes change
			for (int b = 0; b < APB_SW; b++)
			begin
				if (PWSTRB[b])
					regs[idx][8*b +: 8] <= PWDATA[8*b +: 8];
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/apb_subsystem.sv
////////////////////////////////////////
// APB subsystem top level
////////////////////////////////////////

`default_nettype none

module apb_subsystem (
	input  wire                          PCLK,
	input  wire                          arst_n,
	input  wire                          req0,
	output wire                          ack0,
	input  wire                          write0,
	input  wire  [apb_pkg::APB_AW-1:0]   addr0,
	input  wire  [apb_pkg::APB_DW-1:0]   wdata0,
	input  wire  [apb_pkg::APB_SW-1:0]   strb0,
	output wire  [apb_pkg::APB_DW-1:0]   rdata0,
	output wire                          err0,
	input  wire                          req1,
	output wire                          ack1,
	input  wire                          write1,
	input  wire  [apb_pkg::APB_AW-1:0]   addr1,
	input  wire  [apb_pkg::APB_DW-1:0]   wdata1,
	input  wire  [apb_pkg::APB_SW-1:0]   strb1,
	output wire  [apb_pkg::APB_DW-1:0]   rdata1,
	output wire                          err1
);
	import apb_pkg::*;

	// Arbiter to master handshake
	wire mreq;
	wire mack;
	wire mwrite;
	wire [APB_AW-1:0] maddr;
	wire [APB_DW-1:0] mwdata;
	wire [APB_SW-1:0] mstrb;
	wire [APB_DW-1:0] mrdata;
	wire merr;

	// Shared APB bus
	wire psel_reg;
	wire psel_mem;
	wire penable;
	wire [APB_AW-1:0] paddr;
	wire pwrite;
	wire [APB_DW-1:0] pwdata;
	wire [APB_SW-1:0] pwstrb;
	wire pready;
	wire pslverr;

	// Per-slave return paths
	wire [APB_DW-1:0] prdata_reg;
	wire pready_reg;
	wire pslverr_reg;
	wire [APB_DW-1:0] prdata_mem;
	wire pready_mem;
	wire pslverr_mem;

	apb_arbiter u_arbiter (
		.PCLK(PCLK), .arst_n(arst_n),
		.req0(req0), .write0(write0), .addr0(addr0), .wdata0(wdata0), .strb0(strb0),
		.ack0(ack0), .rdata0(rdata0), .err0(err0),
		.req1(req1), .write1(write1), .addr1(addr1), .wdata1(wdata1), .strb1(strb1),
		.ack1(ack1), .rdata1(rdata1), .err1(err1),
		.mreq(mreq), .mwrite(mwrite), .maddr(maddr), .mwdata(mwdata), .mstrb(mstrb),
		.mack(mack), .mrdata(mrdata), .merr(merr)
	);

	apb_master u_master (
		.PCLK(PCLK), .arst_n(arst_n),
		.mreq(mreq), .mwrite(mwrite), .maddr(maddr), .mwdata(mwdata), .mstrb(mstrb),
		.mack(mack), .mrdata(mrdata), .merr(merr),
		.PSEL_REG(psel_reg), .PSEL_MEM(psel_mem), .PENABLE(penable), .PADDR(paddr),
		.PWRITE(pwrite), .PWDATA(pwdata), .PWSTRB(pwstrb),
		.prdata_reg(prdata_reg), .pready_reg(pready_reg), .pslverr_reg(pslverr_reg),
		.prdata_mem(prdata_mem), .pready_mem(pready_mem), .pslverr_mem(pslverr_mem),
		.PREADY(pready), .PSLVERR(pslverr)
	);

	apb_reg_bank u_reg_bank (
		.PCLK(PCLK), .arst_n(arst_n),
		.PSEL(psel_reg), .PENABLE(penable), .PADDR(paddr), .PWRITE(pwrite),
		.PWDATA(pwdata), .PWSTRB(pwstrb),
		.PRDATA(prdata_reg), .PREADY(pready_reg), .PSLVERR(pslverr_reg)
	);

	apb_wait_mem u_wait_mem (
		.PCLK(PCLK), .arst_n(arst_n),
		.PSEL(psel_mem), .PENABLE(penable), .PADDR(paddr), .PWRITE(pwrite),
		.PWDATA(pwdata), .PWSTRB(pwstrb),
		.PRDATA(prdata_mem), .PREADY(pready_mem), .PSLVERR(pslverr_mem)
	);

	// Monitor sees the merged select
	apb_protocol_monitor u_monitor (
		.PCLK(PCLK), .arst_n(arst_n),
		.PSEL(psel_reg | psel_mem), .PENABLE(penable), .PADDR(paddr), .PWRITE(pwrite),
		.PWDATA(pwdata), .PWSTRB(pwstrb), .PREADY(pready), .PSLVERR(pslverr)
	);

endmodule

`default_nettype wire

//--- hw/apb_wait_mem.sv
////////////////////////////////////////
// APB wait-state memory slave
////////////////////////////////////////

`default_nettype none

module apb_wait_mem (
	input  wire                          PCLK,
	input  wire                          arst_n,
	input  wire                          PSEL,
	input  wire                          PENABLE,
	input  wire  [apb_pkg::APB_AW-1:0]   PADDR,
	input  wire                          PWRITE,
	input  wire  [apb_pkg::APB_DW-1:0]   PWDATA,
	input  wire  [apb_pkg::APB_SW-1:0]   PWSTRB,
	output logic [apb_pkg::APB_DW-1:0]   PRDATA,
	output logic                         PREADY,
	output logic                         PSLVERR
);
	import apb_pkg::*;

	// Word index spans every bit below the slave select
	localparam int IDX_W = SEL_BIT - 2;
	localparam int MEM_IW = $clog2(MEM_DEPTH);
	localparam int CNT_W = $clog2(MEM_WAIT + 1);

	logic [APB_DW-1:0] mem [0:MEM_DEPTH-1];
	logic [IDX_W-1:0] word_idx;
	logic [MEM_IW-1:0] mem_idx;
	logic in_range;
	logic access;
	logic [CNT_W-1:0] wait_cnt;

	assign word_idx = PADDR[SEL_BIT-1:2];
	assign mem_idx = PADDR[MEM_IW+1:2];
	assign in_range = word_idx < IDX_W'(MEM_DEPTH);
	assign access = PSEL && PENABLE;

	////////////////////////////////////////
	// Wait states
	////////////////////////////////////////

	// Ready once the counter has run through all wait cycles
	assign PREADY = (wait_cnt == CNT_W'(MEM_WAIT));

	always_ff @(posedge PCLK or negedge arst_n)
	begin
		if (!arst_n)
			wait_cnt <= '0;
		else if (!PSEL || (access && PREADY))
			wait_cnt <= '0;
		else if (access)
			wait_cnt <= wait_cnt + 1'b1;
	end

	////////////////////////////////////////
	// Storage and reply
	////////////////////////////////////////

	// Error only on the completing cycle
	assign PSLVERR = access && PREADY && !in_range;
	assign PRDATA = in_range ? mem[mem_idx] : '0;

	// Write lands on the completing cycle
	always_ff @(posedge PCLK)
	begin
		if (access && PREADY && PWRITE && in_range)
		begin
			for (int b = 0; b < APB_SW; b++)
			begin
				if (PWSTRB[b])
					mem[mem_idx][8*b +: 8] <= PWDATA[8*b +: 8];
			end
		end
	end

	// A stalled access stays selected and enabled
	assert property (@(posedge PCLK) disable iff (!arst_n)
		access && !PREADY |=> PSEL && PENABLE);

endmodule

`default_nettype wire

//--- verification/apb_checker.sv
////////////////////////////////////////
// Requester port checker
////////////////////////////////////////

`default_nettype none

module apb_checker (
	input  wire                          PCLK,
	input  wire                          arst_n,
	input  wire                          req0,
	input  wire                          ack0,
	input  wire  [apb_pkg::APB_DW-1:0]   rdata0,
	input  wire                          err0,
	input  wire                          exp_read0,
	input  wire  [apb_pkg::APB_DW-1:0]   exp_rdata0,
	input  wire                          exp_err0,
	input  wire                          req1,
	input  wire                          ack1,
	input  wire  [apb_pkg::APB_DW-1:0]   rdata1,
	input  wire                          err1,
	input  wire                          exp_read1,
	input  wire  [apb_pkg::APB_DW-1:0]   exp_rdata1,
	input  wire                          exp_err1,
	output int                           errors,
	output int                           acks0,
	output int                           acks1
);
	timeunit 1ns;
	timeprecision 1ps;
	import apb_pkg::*;

	logic req0_q;
	logic ack0_q;
	logic req1_q;
	logic ack1_q;

	// Expected reply held from the rising req
	logic hold_read0;
	logic [APB_DW-1:0] hold_rdata0;
	logic hold_err0;
	logic hold_read1;
	logic [APB_DW-1:0] hold_rdata1;
	logic hold_err1;

	initial
	begin
		errors = 0;
		acks0 = 0;
		acks1 = 0;
	end

	// Reply check on a rising ack, read data only for reads
	function automatic int reply_errors(input int port, input logic is_read,
		input logic [APB_DW-1:0] exp_rdata, input logic exp_err,
		input logic [APB_DW-1:0] rdata, input logic err);
		int found;
		found = 0;
		if (err !== exp_err)
		begin
			$display("Error at %0t ns: port %0d err %b, expected %b", $time, port, err, exp_err);
			found++;
		end
		if (is_read && rdata !== exp_rdata)
		begin
			$display("Error at %0t ns: port %0d read data %h, expected %h",
				$time, port, rdata, exp_rdata);
			found++;
		end
		return found;
	endfunction

	// Four-phase order at one port
	function automatic int handshake_errors(input int port, input logic req,
		input logic req_q, input logic ack, input logic ack_q);
		int found;
		found = 0;
		if (ack && !ack_q && !req)
		begin
			$display("Handshake broken on port %0d: ack rose while req was low", port);
			found++;
		end
		if (!ack && ack_q && req_q)
		begin
			$display("Handshake broken on port %0d: ack fell before req was released", port);
			found++;
		end
		return found;
	endfunction

	////////////////////////////////////////
	// Sampling
	////////////////////////////////////////

	always @(posedge PCLK)
	begin : sample
		int found;
		found = 0;
		if (!arst_n)
		begin
			req0_q <= 1'b0;
			ack0_q <= 1'b0;
			req1_q <= 1'b0;
			ack1_q <= 1'b0;
		end
		else
		begin
			req0_q <= req0;
			ack0_q <= ack0;
			req1_q <= req1;
			ack1_q <= ack1;
			if (req0 && !req0_q)
			begin
				hold_read0 <= exp_read0;
				hold_rdata0 <= exp_rdata0;
				hold_err0 <= exp_err0;
			end
			if (req1 && !req1_q)
			begin
				hold_read1 <= exp_read1;
				hold_rdata1 <= exp_rdata1;
				hold_err1 <= exp_err1;
			end
			if (ack0 && !ack0_q)
			begin
				found += reply_errors(0, hold_read0, hold_rdata0, hold_err0, rdata0, err0);
				acks0 <= acks0 + 1;
			end
			if (ack1 && !ack1_q)
			begin
				found += reply_errors(1, hold_read1, hold_rdata1, hold_err1, rdata1, err1);
				acks1 <= acks1 + 1;
			end
			found += handshake_errors(0, req0, req0_q, ack0, ack0_q);
			found += handshake_errors(1, req1, req1_q, ack1, ack1_q);
			if (ack0 && ack1)
			begin
				$display("Both ports were acknowledged in the same cycle");
				found++;
			end
			errors <= errors + found;
		end
	end

endmodule

`default_nettype wire

//--- verification/apb_golden.txt
// Columns: port write addr wdata strb exp_rdata exp_err, all hex
// Port 0 talks to the register bank, port 1 to the memory; exp_rdata is ignored on writes
0 0 000 00000000 0 A9B00101 0
0 0 004 00000000 0 00000000 0
0 1 004 11223344 F 00000000 0
0 0 004 00000000 0 11223344 0
0 1 004 AABBCCDD 5 00000000 0
0 0 004 00000000 0 11BB33DD 0
0 1 008 CAFEF00D 8 00000000 0
0 0 008 00000000 0 CA000000 0
0 1 03C 12345678 3 00000000 0
0 0 03C 00000000 0 00005678 0
0 1 000 DEADBEEF F 00000000 1
0 0 000 00000000 0 A9B00101 0
0 1 044 FFFFFFFF F 00000000 1
0 0 044 00000000 0 00000000 1
0 0 004 00000000 0 11BB33DD 0
0 0 7FC 00000000 0 00000000 1
1 1 800 01020304 F 00000000 0
1 1 804 A5A5A5A5 F 00000000 0
1 1 8FC 0BADC0DE F 00000000 0
1 0 800 00000000 0 01020304 0
1 0 804 00000000 0 A5A5A5A5 0
1 0 8FC 00000000 0 0BADC0DE 0
1 1 804 FFFF0000 C 00000000 0
1 0 804 00000000 0 FFFFA5A5 0
1 1 900 12345678 F 00000000 1
1 0 900 00000000 0 00000000 1
1 0 FFC 00000000 0 00000000 1
1 0 8FC 00000000 0 0BADC0DE 0

//--- verification/tb_apb_subsystem.sv
////////////////////////////////////////
// APB subsystem testbench
////////////////////////////////////////

`default_nettype none

module tb_apb_subsystem;
	timeunit 1ns;
	timeprecision 1ps;
	import apb_pkg::*;

	// Golden file layout, seven hex words per transfer
	localparam int MAX_LINES = 64;
	localparam int COLS = 7;
	localparam int RESET_CYCLES = 16;
	localparam logic [31:0] NO_LINE = 32'hFFFF_FFFF;

	logic PCLK;
	logic arst_n;

	// Requester port 0, register bank traffic
	logic req0;
	logic write0;
	logic [APB_AW-1:0] addr0;
	logic [APB_DW-1:0] wdata0;
	logic [APB_SW-1:0] strb0;
	wire ack0;
	wire [APB_DW-1:0] rdata0;
	wire err0;

	// Requester port 1, memory traffic
	logic req1;
	logic write1;
	logic [APB_AW-1:0] addr1;
	logic [APB_DW-1:0] wdata1;
	logic [APB_SW-1:0] strb1;
	wire ack1;
	wire [APB_DW-1:0] rdata1;
	wire err1;

	// Expected reply of each driver's current line
	logic exp_read0;
	logic [APB_DW-1:0] exp_rdata0;
	logic exp_err0;
	logic exp_read1;
	logic [APB_DW-1:0] exp_rdata1;
	logic exp_err1;

	logic [31:0] golden [0:MAX_LINES*COLS-1];
	int line_count;
	int lines0;
	int lines1;
	int cycles = 0;
	int cycle_limit;
	int errors;
	int acks0;
	int acks1;

	apb_subsystem uut (
		.PCLK(PCLK), .arst_n(arst_n),
		.req0(req0), .ack0(ack0), .write0(write0), .addr0(addr0), .wdata0(wdata0),
		.strb0(strb0), .rdata0(rdata0), .err0(err0),
		.req1(req1), .ack1(ack1), .write1(write1), .addr1(addr1), .wdata1(wdata1),
		.strb1(strb1), .rdata1(rdata1), .err1(err1)
	);

	apb_checker u_checker (
		.PCLK(PCLK), .arst_n(arst_n),
		.req0(req0), .ack0(ack0), .rdata0(rdata0), .err0(err0),
		.exp_read0(exp_read0), .exp_rdata0(exp_rdata0), .exp_err0(exp_err0),
		.req1(req1), .ack1(ack1), .rdata1(rdata1), .err1(err1),
		.exp_read1(exp_read1), .exp_rdata1(exp_rdata1), .exp_err1(exp_err1),
		.errors(errors), .acks0(acks0), .acks1(acks1)
	);

	// 20 ns period
	initial PCLK = 1'b0;
	always #10 PCLK = ~PCLK;

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	// 8-bit Galois LFSR, taps 8 6 5 4
	function automatic logic [7:0] lfsr_next(input logic [7:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
	endfunction

	function automatic logic ack_of(input int port);
		ack_of = (port == 0) ? ack0 : ack1;
	endfunction

	// Put one golden line on a port and raise req
	task automatic present_line(input int port, input int base);
		if (port == 0)
		begin
			write0 = golden[base+1][0];
			addr0 = golden[base+2][APB_AW-1:0];
			wdata0 = golden[base+3];
			strb0 = golden[base+4][APB_SW-1:0];
			exp_read0 = !golden[base+1][0];
			exp_rdata0 = golden[base+5];
			exp_err0 = golden[base+6][0];
			req0 = 1'b1;
		end
		else
		begin
			write1 = golden[base+1][0];
			addr1 = golden[base+2][APB_AW-1:0];
			wdata1 = golden[base+3];
			strb1 = golden[base+4][APB_SW-1:0];
			exp_read1 = !golden[base+1][0];
			exp_rdata1 = golden[base+5];
			exp_err1 = golden[base+6][0];
			req1 = 1'b1;
		end
	endtask

	// Four-phase requester, walks the lines that belong to one port
	task automatic drive_port(input int port);
		logic [7:0] lfsr;
		logic [1:0] gap;
		int base;
		lfsr = 8'd86;
		for (int n = 0; n < line_count; n++)
		begin
			base = n * COLS;
			if (golden[base] == 32'(port))
			begin
				@(posedge PCLK);
				#2;
				present_line(port, base);
				// Ack sampled on the edge, before the DUT updates
				do
					@(posedge PCLK);
				while (!ack_of(port));
				#2;
				if (port == 0)
					req0 = 1'b0;
				else
					req1 = 1'b0;
				do
					@(posedge PCLK);
				while (ack_of(port));
				// Two LFSR bits per idle gap
				gap[0] = lfsr[0];
				lfsr = lfsr_next(lfsr);
				gap[1] = lfsr[0];
				lfsr = lfsr_next(lfsr);
				repeat (gap) @(posedge PCLK);
			end
		end
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial
	begin
		arst_n = 1'b0;
		req0 = 1'b0;
		write0 = 1'b0;
		addr0 = '0;
		wdata0 = '0;
		strb0 = '0;
		req1 = 1'b0;
		write1 = 1'b0;
		addr1 = '0;
		wdata1 = '0;
		strb1 = '0;
		exp_read0 = 1'b0;
		exp_rdata0 = '0;
		exp_err0 = 1'b0;
		exp_read1 = 1'b0;
		exp_rdata1 = '0;
		exp_err1 = 1'b0;

		// Unused lines keep a port value that marks the end
		for (int i = 0; i < MAX_LINES; i++)
			golden[i*COLS] = NO_LINE;
		$readmemh("verification/apb_golden.txt", golden);
		line_count = 0;
		lines0 = 0;
		lines1 = 0;
		while (line_count < MAX_LINES && golden[line_count*COLS] != NO_LINE)
		begin
			if (golden[line_count*COLS] == 32'd0)
				lines0++;
			else
				lines1++;
			line_count++;
		end
		cycle_limit = line_count * 20 + 100;

		repeat (RESET_CYCLES) @(posedge PCLK);
		#2;
		arst_n = 1'b1;

		// Both requesters compete for the bus
		fork
			drive_port(0);
			drive_port(1);
		join
		repeat (4) @(posedge PCLK);

		if (line_count == 0)
			$display("The golden file holds no transfers");
		if (acks0 != lines0 || acks1 != lines1)
			$display("Not every golden line was answered by an ack");
		$display("Errors: %0d, port 0 acks %0d of %0d, port 1 acks %0d of %0d",
			errors, acks0, lines0, acks1, lines1);
		if (errors == 0 && line_count > 0 && acks0 == lines0 && acks1 == lines1)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	// Watchdog
	always @(posedge PCLK)
	begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit)
		begin
			$display("The run timed out after %0d cycles before all transfers finished",
				cycles);
			$display("Errors: %0d", errors);
			$display("Verification failed");
			$finish;
		end
	end

endmodule

`default_nettype wire
